// File: verilog.f
src/pcs_pkg.sv
src/pcs_ctrl_if.sv
src/register_file.sv
src/block_gen.sv
src/pcs_lane.sv
src/block_logger.sv
src/pcs_check_top.sv
dv/tb_pcs_check.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the PCS loopback testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_pcs_check -f verilog.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out="$(./obj_dir/sim_tb 2>&1)"
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "TESTS PASSED"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: dv/tb_pcs_check.sv
`timescale 1ns/1ps

module tb_pcs_check
	import pcs_pkg::*;
	();

	localparam int CLK_PERIOD = 4;
	localparam int FRAME_LEN  = 1 + FRAME_DATA_BLOCKS + 1 + IDLE_GAP;
	localparam int LOG_DEPTH  = 2**NB_ADDR_RAM;
	localparam int N_RAND     = 16; // Random reads per run
	localparam int N_PHASES   = 3;
	localparam int N_CMDS     = N_PHASES * (2 + N_RAND) + LOG_DEPTH;
	localparam int DRAIN      = 4;

	logic                      clk;
	logic                      arst_n;
	logic                      cmd_valid;
	logic [NB_CMD-1:0]         cmd;
	logic                      log_valid;
	logic [LEN_DATA_BLOCK-1:0] log_tx_data;
	logic [LEN_CTRL_BLOCK-1:0] log_tx_ctrl;
	logic [LEN_DATA_BLOCK-1:0] log_rx_data;
	logic [LEN_CTRL_BLOCK-1:0] log_rx_ctrl;
	logic                      mem_full;

	logic                   cmd_run;
	logic                   cmd_read;
	logic [2:0]             read_pipe;
	logic [NB_LANE_SEL-1:0] lane_pipe [3];
	logic [NB_ADDR_RAM-1:0] addr_pipe [3];
	logic                   run_d1;
	logic                   run_d2;
	logic                   seen_cmd;
	logic                   diff_seen;
	logic                   expect_match; // Low while the scrambler runs alone
	logic                   phase_end;
	logic [7:0]             exp_ctrl;
	logic [63:0]            exp_chars;
	logic [63:0]            exp_mask;
	int                     seed;
	int                     reads_issued;
	int                     reads_back;

	pcs_check_top dut0 (
		.i_clock       (clk),
		.i_arst_n      (arst_n),
		.i_cmd_valid   (cmd_valid),
		.i_cmd         (cmd),
		.o_log_valid   (log_valid),
		.o_log_tx_data (log_tx_data),
		.o_log_tx_ctrl (log_tx_ctrl),
		.o_log_rx_data (log_rx_data),
		.o_log_rx_ctrl (log_rx_ctrl),
		.o_mem_full    (mem_full)
	);

	always #(CLK_PERIOD/2) clk = ~clk;

	//////////////////////////////////////////////////
	// Frame rule reference
	//////////////////////////////////////////////////
	function automatic logic [7:0] frame_ctrl(input int addr);
		int pos;
		pos = addr % FRAME_LEN;
		if (pos == 0)
			return 8'h01;
		else if (pos <= FRAME_DATA_BLOCKS)
			return 8'h00;
		else if (pos == FRAME_DATA_BLOCKS + 1)
			return 8'hFF << ((addr / FRAME_LEN) % 8); // Terminate moves each frame
		return 8'hFF;
	endfunction

	function automatic logic [63:0] frame_chars(input int addr);
		int          pos;
		logic [63:0] d;
		pos = addr % FRAME_LEN;
		d   = {8{CH_IDLE}};
		if (pos == 0)
			d[7:0] = CH_START;
		else if (pos == FRAME_DATA_BLOCKS + 1)
			d[8*((addr / FRAME_LEN) % 8) +: 8] = CH_TERM;
		return d;
	endfunction

	function automatic logic [63:0] byte_mask(input logic [7:0] c);
		logic [63:0] m;
		for (int b = 0; b < 8; b++)
			m[8*b +: 8] = {8{c[b]}};
		return m;
	endfunction

	assign cmd_run  = cmd_valid && (cmd[NB_CMD-1 -: NB_OPCODE] == OP_RUN);
	assign cmd_read = cmd_valid && (cmd[NB_CMD-1 -: NB_OPCODE] == OP_READ);

	always_comb begin
		exp_ctrl  = frame_ctrl(int'(addr_pipe[2]));
		exp_chars = frame_chars(int'(addr_pipe[2]));
		exp_mask  = byte_mask(exp_ctrl);
	end

	// Tracks reads in flight, runs and scrambled entries
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			read_pipe  <= '0;
			run_d1     <= 1'b0;
			run_d2     <= 1'b0;
			seen_cmd   <= 1'b0;
			diff_seen  <= 1'b0;
			reads_back <= 0;
			for (int i = 0; i < 3; i++) begin
				lane_pipe[i] <= '0;
				addr_pipe[i] <= '0;
			end
		end else begin
			read_pipe    <= {read_pipe[1:0], cmd_read};
			lane_pipe[0] <= cmd[CMD_LANE_LSB +: NB_LANE_SEL];
			addr_pipe[0] <= cmd[NB_ADDR_RAM-1:0];
			for (int i = 1; i < 3; i++) begin
				lane_pipe[i] <= lane_pipe[i-1];
				addr_pipe[i] <= addr_pipe[i-1];
			end
			run_d1 <= cmd_run;
			run_d2 <= run_d1;
			if (cmd_valid)
				seen_cmd <= 1'b1;
			if (log_valid)
				reads_back <= reads_back + 1;
			if (cmd_run)
				diff_seen <= 1'b0;
			else if (log_valid && {log_rx_data, log_rx_ctrl} != {log_tx_data, log_tx_ctrl})
				diff_seen <= 1'b1;
		end
	end

	task automatic abort_run();
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic fail_value(input string sig, input logic [63:0] got, input logic [63:0] exp);
		$display("FAIL time=%0t signal=%s got=%h expected=%h", $time, sig, got, exp);
		abort_run();
	endtask

	task automatic fail_text(input string what);
		$display("Error at time %0t: %s", $time, what);
		abort_run();
	endtask

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////
	a_quiet_valid: assert property (@(posedge clk) disable iff (!arst_n)
		!seen_cmd |-> !log_valid)
		else fail_value("o_log_valid", 64'($sampled(log_valid)), 64'd0);
	a_quiet_full: assert property (@(posedge clk) disable iff (!arst_n)
		!seen_cmd |-> !mem_full)
		else fail_value("o_mem_full", 64'($sampled(mem_full)), 64'd0);
	a_read_latency: assert property (@(posedge clk) disable iff (!arst_n)
		log_valid == read_pipe[2])
		else fail_value("o_log_valid", 64'($sampled(log_valid)), 64'($sampled(read_pipe[2])));
	a_rx_data: assert property (@(posedge clk) disable iff (!arst_n)
		log_valid && expect_match |-> log_rx_data == log_tx_data)
		else fail_value("o_log_rx_data", $sampled(log_rx_data), $sampled(log_tx_data));
	a_rx_ctrl: assert property (@(posedge clk) disable iff (!arst_n)
		log_valid && expect_match |-> log_rx_ctrl == log_tx_ctrl)
		else fail_value("o_log_rx_ctrl", 64'($sampled(log_rx_ctrl)), 64'($sampled(log_tx_ctrl)));
	a_frame_ctrl: assert property (@(posedge clk) disable iff (!arst_n)
		log_valid && lane_pipe[2] == '0 |-> log_tx_ctrl == exp_ctrl)
		else fail_value("o_log_tx_ctrl", 64'($sampled(log_tx_ctrl)), 64'($sampled(exp_ctrl)));
	a_frame_data: assert property (@(posedge clk) disable iff (!arst_n)
		log_valid && lane_pipe[2] == '0 |-> (log_tx_data & exp_mask) == (exp_chars & exp_mask))
		else fail_value("o_log_tx_data", $sampled(log_tx_data) & $sampled(exp_mask),
			$sampled(exp_chars) & $sampled(exp_mask));
	a_scr_diff: assert property (@(posedge clk) disable iff (!arst_n)
		phase_end && !expect_match |-> diff_seen)
		else fail_text("no read entry differed with the descrambler disabled");
	a_full_hold: assert property (@(posedge clk) disable iff (!arst_n)
		mem_full && !cmd_run && !run_d1 |=> mem_full)
		else fail_value("o_mem_full", 64'($sampled(mem_full)), 64'd1);
	a_full_clear: assert property (@(posedge clk) disable iff (!arst_n)
		run_d2 |-> !mem_full)
		else fail_value("o_mem_full", 64'($sampled(mem_full)), 64'd0);

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic send_cmd(input logic [NB_CMD-1:0] word);
		next_cycle();
		cmd_valid = 1'b1;
		cmd       = word;
	endtask

	task automatic go_idle();
		next_cycle();
		cmd_valid = 1'b0;
		cmd       = '0;
	endtask

	task automatic read_entry(input logic [NB_LANE_SEL-1:0] lane,
		input logic [NB_ADDR_RAM-1:0] addr);
		logic [NB_CMD-1:0] w;
		w                                = '0;
		w[NB_CMD-1 -: NB_OPCODE]         = OP_READ;
		w[CMD_LANE_LSB +: NB_LANE_SEL]   = lane;
		w[NB_ADDR_RAM-1:0]               = addr;
		send_cmd(w);
		reads_issued++;
	endtask

	// Enables are enc, scr, descr, dec from bit 3 down
	task automatic run_phase(input logic [3:0] enables, input logic match, input logic sweep);
		logic [31:0] rnd;
		expect_match = match;
		send_cmd({OP_SET_ENABLES, {(NB_CMD-NB_OPCODE-4){1'b0}}, enables});
		send_cmd({OP_RUN, {(NB_CMD-NB_OPCODE){1'b0}}});
		go_idle();
		while (mem_full)
			next_cycle(); // Old log clears first
		while (!mem_full)
			next_cycle();
		if (sweep) begin
			for (int a = 0; a < LOG_DEPTH; a++)
				read_entry('0, NB_ADDR_RAM'(a));
		end
		for (int i = 0; i < N_RAND; i++) begin
			rnd = $random(seed);
			read_entry(rnd[CMD_LANE_LSB +: NB_LANE_SEL], rnd[NB_ADDR_RAM-1:0]);
		end
		go_idle();
		repeat (DRAIN) next_cycle();
		phase_end = 1'b1;
		next_cycle();
		phase_end = 1'b0;
	endtask

	initial begin
		#(N_CMDS * 200 * CLK_PERIOD);
		fail_text("watchdog expired before the test sequence finished");
	end

	initial begin
		clk          = 1'b0;
		arst_n       = 1'b0;
		cmd_valid    = 1'b0;
		cmd          = '0;
		expect_match = 1'b1;
		phase_end    = 1'b0;
		seed         = 32'ha4a7_4489;
		reads_issued = 0;
		repeat (2) @(posedge clk);
		#1;
		arst_n = 1'b1;
		repeat (5) next_cycle(); // Quiet window before any command
		run_phase(4'b1111, 1'b1, 1'b1);
		run_phase(4'b1101, 1'b0, 1'b0);
		run_phase(4'b1001, 1'b1, 1'b0);
		if (reads_back != reads_issued) begin
			fail_text("number of log reads returned differs from reads issued");
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

// File: src/pcs_check_top.sv
`timescale 1ns/1ps

module pcs_check_top
	import pcs_pkg::*;
	(
	input  logic                      i_clock,
	input  logic                      i_arst_n,
	input  logic                      i_cmd_valid,
	input  logic [NB_CMD-1:0]         i_cmd,
	output logic                      o_log_valid,
	output logic [LEN_DATA_BLOCK-1:0] o_log_tx_data,
	output logic [LEN_CTRL_BLOCK-1:0] o_log_tx_ctrl,
	output logic [LEN_DATA_BLOCK-1:0] o_log_rx_data,
	output logic [LEN_CTRL_BLOCK-1:0] o_log_rx_ctrl,
	output logic                      o_mem_full
	);

	pcs_ctrl_if ctrl_if ();

	xgmii_blk_t tx_blk     [N_LANES];
	xgmii_blk_t tx_blk_dly [N_LANES];
	xgmii_blk_t rx_blk     [N_LANES];
	logic       rx_valid   [N_LANES];
	logic       tx_valid;
	log_word_t  log_word;

	register_file u_register_file (
		.i_clock     (i_clock),
		.i_arst_n    (i_arst_n),
		.i_cmd_valid (i_cmd_valid),
		.i_cmd       (i_cmd),
		.ctrl        (ctrl_if.regs)
	);

	block_gen u_block_gen (
		.i_clock      (i_clock),
		.i_arst_n     (i_arst_n),
		.ctrl         (ctrl_if.gen),
		.i_stop       (o_mem_full),
		.o_tx_blk     (tx_blk),
		.o_tx_valid   (tx_valid),
		.o_tx_blk_dly (tx_blk_dly)
	);

	for (genvar l = 0; l < N_LANES; l++) begin : g_lane
		pcs_lane u_pcs_lane (
			.i_clock  (i_clock),
			.i_arst_n (i_arst_n),
			.ctrl     (ctrl_if.lane),
			.i_blk    (tx_blk[l]),
			.i_valid  (tx_valid),
			.o_blk    (rx_blk[l]),
			.o_valid  (rx_valid[l])
		);
	end

	block_logger u_block_logger (
		.i_clock     (i_clock),
		.i_arst_n    (i_arst_n),
		.ctrl        (ctrl_if.log),
		.i_tx_blk    (tx_blk_dly),
		.i_rx_blk    (rx_blk),
		.i_rx_valid  (rx_valid),
		.o_log_valid (o_log_valid),
		.o_log_word  (log_word),
		.o_mem_full  (o_mem_full)
	);

	assign o_log_tx_data = log_word.tx.data;
	assign o_log_tx_ctrl = log_word.tx.ctrl;
	assign o_log_rx_data = log_word.rx.data;
	assign o_log_rx_ctrl = log_word.rx.ctrl;

endmodule

// File: src/block_logger.sv
`timescale 1ns/1ps

module block_logger
	import pcs_pkg::*;
	(
	input  logic       i_clock,
	input  logic       i_arst_n,
	pcs_ctrl_if.log    ctrl,
	input  xgmii_blk_t i_tx_blk   [N_LANES],
	input  xgmii_blk_t i_rx_blk   [N_LANES],
	input  logic       i_rx_valid [N_LANES],
	output logic       o_log_valid,
	output log_word_t  o_log_word,
	output logic       o_mem_full
	);

	localparam int DEPTH = 2**NB_ADDR_RAM;

	log_word_t              mem [N_LANES][DEPTH];
	logic [NB_ADDR_RAM-1:0] wr_ptr;
	logic                   wr_en;
	logic                   full;
	log_word_t              rd_q;
	logic                   rd_vld_q;

	// Lane 0 paces the shared pointer
	assign wr_en = i_rx_valid[0] && !full && !ctrl.run;

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr <= '0;
			full   <= 1'b0;
		end else if (ctrl.run) begin
			wr_ptr <= '0; // Clear log
			full   <= 1'b0;
		end else if (wr_en) begin
			wr_ptr <= wr_ptr + 1'b1;
			if (wr_ptr == NB_ADDR_RAM'(DEPTH - 1))
				full <= 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (wr_en) begin
			for (int l = 0; l < N_LANES; l++)
				mem[l][wr_ptr] <= '{tx: i_tx_blk[l], rx: i_rx_blk[l]};
		end
	end

	//////////////////////////////////////////////////
	// Two-stage read
	//////////////////////////////////////////////////
	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			rd_vld_q    <= 1'b0;
			o_log_valid <= 1'b0;
		end else begin
			rd_vld_q    <= ctrl.rd_en;
			o_log_valid <= rd_vld_q;
		end
	end

	always_ff @(posedge i_clock) begin
		if (ctrl.rd_en)
			rd_q <= mem[ctrl.rd_lane][ctrl.rd_addr];
		if (rd_vld_q)
			o_log_word <= rd_q;
	end

	assign o_mem_full = full;

	// Once full, the log holds until the next run
	a_no_wr_full: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		full && !ctrl.run |=> full && $stable(wr_ptr));

endmodule

// File: src/pcs_lane.sv
`timescale 1ns/1ps

module pcs_lane
	import pcs_pkg::*;
	(
	input  logic       i_clock,
	input  logic       i_arst_n,
	pcs_ctrl_if.lane   ctrl,
	input  xgmii_blk_t i_blk,
	input  logic       i_valid,
	output xgmii_blk_t o_blk,
	output logic       o_valid
	);

	localparam int NB_SCR = SCR_TAP_B + 1;

	// Terminate types by byte position
	localparam logic [8*LEN_TYPE-1:0] TERM_TYPES = {BT_TERM7, BT_TERM6, BT_TERM5, BT_TERM4,
		BT_TERM3, BT_TERM2, BT_TERM1, BT_TERM0};

	logic [LEN_CODED_BLOCK-1:0] enc_c, s1_code, s2_code, s3_code;
	logic [LEN_CTRL_BLOCK-1:0]  s1_raw, s2_raw, s3_raw; // Ctrl kept for decoder bypass
	logic [3:0]                 vld;
	logic [NB_SCR-1:0]          scr_st, scr_st_n, dsc_st, dsc_st_n;
	logic [LEN_DATA_BLOCK-1:0]  scr_d, dsc_d;
	xgmii_blk_t                 dec_c;
	logic [LEN_DATA_BLOCK-1:0]  pl;

	//////////////////////////////////////////////////
	// Encoder
	//////////////////////////////////////////////////
	always_comb begin
		enc_c = {i_blk.data, 2'b01};
		pl    = '0;
		if (ctrl.en_encoder && i_blk.ctrl != '0) begin
			enc_c = {{8{7'h1E}}, BT_IDLE, 2'b10}; // Error unless matched below
			if (i_blk.ctrl == 8'hFF && i_blk.data == {8{CH_IDLE}})
				enc_c = {56'h0, BT_IDLE, 2'b10};
			else if (i_blk.ctrl == 8'h01 && i_blk.data[7:0] == CH_START)
				enc_c = {i_blk.data[63:8], BT_START, 2'b10};
			for (int k = 0; k < 8; k++) begin
				if (i_blk.ctrl == (8'hFF << k) && i_blk.data[8*k +: 8] == CH_TERM) begin
					for (int b = 0; b < k; b++)
						pl[8 + 8*b +: 8] = i_blk.data[8*b +: 8];
					enc_c = {pl[63:8], TERM_TYPES[8*k +: 8], 2'b10};
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Self-synchronizing scrambler and descrambler
	//////////////////////////////////////////////////
	always_comb begin
		scr_st_n = scr_st;
		dsc_st_n = dsc_st;
		for (int i = 0; i < LEN_DATA_BLOCK; i++) begin
			scr_d[i] = s1_code[2+i] ^ scr_st_n[SCR_TAP_A] ^ scr_st_n[SCR_TAP_B];
			scr_st_n = {scr_st_n[NB_SCR-2:0], scr_d[i]};
			dsc_d[i] = s2_code[2+i] ^ dsc_st_n[SCR_TAP_A] ^ dsc_st_n[SCR_TAP_B];
			dsc_st_n = {dsc_st_n[NB_SCR-2:0], s2_code[2+i]};
		end
	end

	//////////////////////////////////////////////////
	// Decoder
	//////////////////////////////////////////////////
	always_comb begin
		dec_c.data = {8{CH_ERROR}};
		dec_c.ctrl = 8'hFF;
		if (!ctrl.en_decoder) begin
			dec_c.data = s3_code[65:2];
			dec_c.ctrl = s3_raw;
		end else if (s3_code[1:0] == 2'b01) begin
			dec_c.data = s3_code[65:2];
			dec_c.ctrl = '0;
		end else if (s3_code[1:0] == 2'b10) begin
			case (s3_code[9:2])
				BT_IDLE: begin
					for (int b = 0; b < 8; b++)
						dec_c.data[8*b +: 8] = (s3_code[10 + 7*b +: 7] == 7'h00) ?
							CH_IDLE : CH_ERROR;
				end
				BT_START: begin
					dec_c.data = {s3_code[65:10], CH_START};
					dec_c.ctrl = 8'h01;
				end
				BT_TERM0, BT_TERM1, BT_TERM2, BT_TERM3,
				BT_TERM4, BT_TERM5, BT_TERM6, BT_TERM7: begin
					for (int k = 0; k < 8; k++) begin
						if (s3_code[9:2] == TERM_TYPES[8*k +: 8]) begin
							dec_c.ctrl = 8'hFF << k;
							for (int b = 0; b < 8; b++) begin
								if (b < k)
									dec_c.data[8*b +: 8] = s3_code[10 + 8*b +: 8];
								else if (b == k)
									dec_c.data[8*b +: 8] = CH_TERM;
								else
									dec_c.data[8*b +: 8] = CH_IDLE;
							end
						end
					end
				end
				default: ; // Unknown type stays an error block
			endcase
		end
	end

	// Four-stage pipeline
	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			vld    <= '0;
			scr_st <= '1;
			dsc_st <= '1;
		end else begin
			vld <= {vld[2:0], i_valid};
			if (vld[0] && ctrl.en_scrambler)
				scr_st <= scr_st_n;
			if (vld[1] && ctrl.en_descrambler)
				dsc_st <= dsc_st_n;
		end
	end

	always_ff @(posedge i_clock) begin
		s1_code <= enc_c;
		s1_raw  <= i_blk.ctrl;
		s2_code <= ctrl.en_scrambler ? {scr_d, s1_code[1:0]} : s1_code;
		s2_raw  <= s1_raw;
		s3_code <= ctrl.en_descrambler ? {dsc_d, s2_code[1:0]} : s2_code;
		s3_raw  <= s2_raw;
		o_blk   <= dec_c;
	end

	assign o_valid = vld[3];

	a_hdr_legal: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		i_valid && ctrl.en_encoder |=> (s1_code[1:0] == 2'b01 || s1_code[1:0] == 2'b10));

endmodule

// File: src/block_gen.sv
`timescale 1ns/1ps

module block_gen
	import pcs_pkg::*;
	(
	input  logic       i_clock,
	input  logic       i_arst_n,
	pcs_ctrl_if.gen    ctrl,
	input  logic       i_stop,
	output xgmii_blk_t o_tx_blk     [N_LANES],
	output logic       o_tx_valid,
	output xgmii_blk_t o_tx_blk_dly [N_LANES] // Aligned with lane outputs
	);

	typedef enum logic [2:0] {ST_OFF, ST_START, ST_DATA, ST_TERM, ST_GAP} gen_state_t;

	gen_state_t  state;
	logic [2:0]  count;
	logic [2:0]  term_pos;
	logic [31:0] lfsr [N_LANES];
	xgmii_blk_t  blk  [N_LANES];
	xgmii_blk_t  dly  [N_LANES][3];

	// Block contents for the current state
	always_comb begin
		for (int l = 0; l < N_LANES; l++) begin
			blk[l].data = {lfsr[l], ~lfsr[l]};
			blk[l].ctrl = '0;
			case (state)
				ST_START: begin
					blk[l].data[7:0] = CH_START;
					blk[l].ctrl      = 8'h01;
				end
				ST_TERM: begin
					for (int b = 0; b < 8; b++) begin
						if (b == term_pos)
							blk[l].data[8*b +: 8] = CH_TERM;
						else if (b > term_pos)
							blk[l].data[8*b +: 8] = CH_IDLE;
					end
					blk[l].ctrl = 8'hFF << term_pos;
				end
				ST_GAP, ST_OFF: begin
					blk[l].data = {8{CH_IDLE}};
					blk[l].ctrl = 8'hFF;
				end
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Frame FSM
	//////////////////////////////////////////////////
	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state    <= ST_OFF;
			count    <= '0;
			term_pos <= '0;
		end else if (ctrl.run) begin
			state    <= ST_START;
			count    <= '0;
			term_pos <= '0;
		end else if (i_stop) begin
			state <= ST_OFF;
		end else begin
			case (state)
				ST_START: begin
					state <= ST_DATA;
					count <= '0;
				end
				ST_DATA: begin
					count <= count + 3'd1;
					if (count == 3'(FRAME_DATA_BLOCKS - 1))
						state <= ST_TERM;
				end
				ST_TERM: begin
					state    <= ST_GAP;
					count    <= '0;
					term_pos <= term_pos + 3'd1; // Next frame ends one byte later
				end
				ST_GAP: begin
					count <= count + 3'd1;
					if (count == 3'(IDLE_GAP - 1))
						state <= ST_START;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_tx_valid <= 1'b0;
			for (int l = 0; l < N_LANES; l++)
				lfsr[l] <= 32'hACE1_0000 + 32'(l * 32'h1357_9BDF) + 32'd1;
		end else begin
			o_tx_valid <= (state != ST_OFF) && !i_stop && !ctrl.run;
			for (int l = 0; l < N_LANES; l++) begin
				if (state != ST_OFF) // Galois step
					lfsr[l] <= (lfsr[l] >> 1) ^ (lfsr[l][0] ? 32'h8020_0003 : 32'h0);
			end
		end
	end

	always_ff @(posedge i_clock) begin
		for (int l = 0; l < N_LANES; l++) begin
			o_tx_blk[l] <= blk[l];
			dly[l][0]   <= o_tx_blk[l];
			for (int d = 1; d < 3; d++)
				dly[l][d] <= dly[l][d-1];
			o_tx_blk_dly[l] <= dly[l][2]; // Four cycles after o_tx_blk
		end
	end

endmodule

// File: src/register_file.sv
`timescale 1ns/1ps

module register_file
	import pcs_pkg::*;
	(
	input  logic              i_clock,
	input  logic              i_arst_n,
	input  logic              i_cmd_valid,
	input  logic [NB_CMD-1:0] i_cmd,
	pcs_ctrl_if.regs          ctrl
	);

	logic [NB_OPCODE-1:0]   opcode;
	logic                   is_set;
	logic                   is_run;
	logic                   is_read;
	logic [3:0]             enables;
	logic                   run_q;
	logic                   rd_en_q;
	logic [NB_ADDR_RAM-1:0] rd_addr_q;
	logic [NB_LANE_SEL-1:0] rd_lane_q;

	assign opcode  = i_cmd[NB_CMD-1 -: NB_OPCODE];
	assign is_set  = i_cmd_valid && (opcode == OP_SET_ENABLES);
	assign is_run  = i_cmd_valid && (opcode == OP_RUN);
	assign is_read = i_cmd_valid && (opcode == OP_READ);

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			enables <= '0;
			run_q   <= 1'b0;
			rd_en_q <= 1'b0;
		end else begin
			run_q   <= is_run;
			rd_en_q <= is_read;
			if (is_set)
				enables <= i_cmd[3:0]; // enc, scr, descr, dec from bit 3 down
		end
	end

	// Lane and address of a read request
	always_ff @(posedge i_clock) begin
		if (is_read) begin
			rd_addr_q <= i_cmd[NB_ADDR_RAM-1:0];
			rd_lane_q <= i_cmd[CMD_LANE_LSB +: NB_LANE_SEL];
		end
	end

	assign ctrl.en_encoder     = enables[3];
	assign ctrl.en_scrambler   = enables[2];
	assign ctrl.en_descrambler = enables[1];
	assign ctrl.en_decoder     = enables[0];
	assign ctrl.run            = run_q;
	assign ctrl.rd_en          = rd_en_q;
	assign ctrl.rd_addr        = rd_addr_q;
	assign ctrl.rd_lane        = rd_lane_q;

	a_run_rd_excl: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		!(ctrl.run && ctrl.rd_en));

endmodule

// File: src/pcs_ctrl_if.sv
`timescale 1ns/1ps

interface pcs_ctrl_if
	import pcs_pkg::*;
	();

	logic                   run;            // One cycle pulse
	logic                   en_encoder;
	logic                   en_scrambler;
	logic                   en_descrambler;
	logic                   en_decoder;
	logic                   rd_en;
	logic [NB_ADDR_RAM-1:0] rd_addr;
	logic [NB_LANE_SEL-1:0] rd_lane;

	// Register file side
	modport regs (
		output run, en_encoder, en_scrambler, en_descrambler, en_decoder,
		output rd_en, rd_addr, rd_lane
	);

	modport gen (input run);

	modport lane (input en_encoder, en_scrambler, en_descrambler, en_decoder);

	modport log (input run, rd_en, rd_addr, rd_lane);

endinterface

// File: src/pcs_pkg.sv
package pcs_pkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////
	localparam int N_LANES         = 4;
	localparam int LEN_DATA_BLOCK  = 64;
	localparam int LEN_CTRL_BLOCK  = 8;
	localparam int LEN_CODED_BLOCK = 66;
	localparam int LEN_TYPE        = 8;
	localparam int NB_ADDR_RAM     = 6;
	localparam int NB_LANE_SEL     = $clog2(N_LANES);
	localparam int NB_CMD          = 32;
	localparam int NB_OPCODE       = 4;

	// Lane select field of a command word
	localparam int CMD_LANE_LSB    = 8;

	localparam logic [NB_OPCODE-1:0] OP_SET_ENABLES = 4'h1;
	localparam logic [NB_OPCODE-1:0] OP_RUN         = 4'h2;
	localparam logic [NB_OPCODE-1:0] OP_READ        = 4'h3;

	//////////////////////////////////////////////////
	// 64b/66b block types
	//////////////////////////////////////////////////
	localparam logic [LEN_TYPE-1:0] BT_IDLE  = 8'h1E;
	localparam logic [LEN_TYPE-1:0] BT_START = 8'h78;
	localparam logic [LEN_TYPE-1:0] BT_TERM0 = 8'h87;
	localparam logic [LEN_TYPE-1:0] BT_TERM1 = 8'h99;
	localparam logic [LEN_TYPE-1:0] BT_TERM2 = 8'hAA;
	localparam logic [LEN_TYPE-1:0] BT_TERM3 = 8'hB4;
	localparam logic [LEN_TYPE-1:0] BT_TERM4 = 8'hCC;
	localparam logic [LEN_TYPE-1:0] BT_TERM5 = 8'hD2;
	localparam logic [LEN_TYPE-1:0] BT_TERM6 = 8'hE1;
	localparam logic [LEN_TYPE-1:0] BT_TERM7 = 8'hFF;

	localparam logic [7:0] CH_IDLE  = 8'h07;
	localparam logic [7:0] CH_START = 8'hFB;
	localparam logic [7:0] CH_TERM  = 8'hFD;
	localparam logic [7:0] CH_ERROR = 8'hFE;

	localparam int FRAME_DATA_BLOCKS = 5;
	localparam int IDLE_GAP          = 2;

	localparam int SCR_TAP_A = 38; // x^39
	localparam int SCR_TAP_B = 57; // x^58

	typedef struct packed {
		logic [LEN_DATA_BLOCK-1:0] data;
		logic [LEN_CTRL_BLOCK-1:0] ctrl;
	} xgmii_blk_t;

	typedef struct packed {
		xgmii_blk_t tx;
		xgmii_blk_t rx;
	} log_word_t;

endpackage
